/* Bender.yml */
package:
  name: uart_string_link

sources:
  - design/uart_cfg_pkg.sv
  - design/str_frame_pkg.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/frame_tx.sv
  - design/frame_rx.sv
  - design/uart_string_link.sv
  - target: test
    files:
      - tests/uart_string_link_tb.sv

/* design/frame_rx.sv */
// String frame receiver.
// Hunts for "&&" in the received byte stream, collects the content up to
// the closing "&&" and presents it with its length and a truncation flag.

module frame_rx
	import uart_cfg_pkg::*;
	import str_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  uart_byte_t rx_byte,
	input  logic       vld,
	output str_buf_t   rx_str,
	output logic       rx_busy,
	output logic       rx_done
);

	frx_state_t state;
	str_len_t   work_len;
	logic       work_trunc;
	uart_byte_t [STR_MAX_LEN-1:0] work_data;

	logic     is_delim;
	logic     open;       // Second opening '&'.
	logic     wr_one;     // Plain content byte.
	logic     wr_amp;     // Held '&' plus the byte after it.
	logic     close;
	str_len_t len_nxt;

	assign is_delim = vld && (rx_byte == FRAME_DELIM);
	assign open     = (state == FRX_OPEN2) && is_delim;
	assign wr_one   = (state == FRX_BODY) && vld && !is_delim;
	assign wr_amp   = (state == FRX_AMP) && vld && !is_delim;
	assign close    = (state == FRX_AMP) && is_delim;
	assign len_nxt  = work_len + 1'b1;

	assign rx_busy = (state == FRX_BODY) || (state == FRX_AMP);
	assign rx_done = (state == FRX_DONE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= FRX_HUNT;
		end else begin
			case (state)
				FRX_HUNT, FRX_DONE: state <= is_delim ? FRX_OPEN2 : FRX_HUNT;
				FRX_OPEN2: if (vld) begin
					state <= is_delim ? FRX_BODY : FRX_HUNT;
				end
				FRX_BODY: if (is_delim) begin
					state <= FRX_AMP;
				end
				FRX_AMP: if (vld) begin
					state <= is_delim ? FRX_DONE : FRX_BODY;
				end
				default: state <= FRX_HUNT;
			endcase
		end
	end

	// Length and overflow tracking of the frame in progress.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			work_len   <= '0;
			work_trunc <= 1'b0;
		end else if (open) begin
			work_len   <= '0;
			work_trunc <= 1'b0;
		end else if (wr_one) begin
			if (work_len < STR_MAX_LEN) begin
				work_len <= len_nxt;
			end else begin
				work_trunc <= 1'b1;
			end
		end else if (wr_amp) begin
			if (work_len < STR_MAX_LEN - 1) begin
				work_len <= work_len + 6'd2;
			end else begin
				work_len   <= str_len_t'(STR_MAX_LEN);  // Room for one at most.
				work_trunc <= 1'b1;
			end
		end
	end

	// Content bytes, cleared at each new frame.
	always_ff @(posedge sys_clk) begin
		if (open) begin
			work_data <= '0;
		end else if (wr_one) begin
			if (work_len < STR_MAX_LEN) work_data[work_len] <= rx_byte;
		end else if (wr_amp) begin
			if (work_len < STR_MAX_LEN) work_data[work_len] <= FRAME_DELIM;
			if (len_nxt < STR_MAX_LEN) work_data[len_nxt] <= rx_byte;
		end
	end

	// Result holds until the next frame closes.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_str <= '0;
		end else if (close) begin
			rx_str <= '{data: work_data, len: work_len, trunc: work_trunc};
		end
	end

endmodule

/* design/frame_tx.sv */
// String frame transmitter.
// Captures a string on request and sends "&&", the content and "&&"
// byte by byte through the UART transmitter.

module frame_tx
	import uart_cfg_pkg::*;
	import str_frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  str_buf_t   tx_str,
	input  logic       tx_req,
	output logic       tx_busy,
	output logic       tx_done,
	output uart_byte_t tx_byte,
	output logic       req,
	input  logic       byte_done
);

	ftx_state_t state;
	str_len_t   idx;    // Content byte on the line.
	str_len_t   len_q;
	uart_byte_t [STR_MAX_LEN-1:0] data_q;

	logic start;

	assign tx_busy = (state != FTX_IDLE) && (state != FTX_DONE);
	assign tx_done = (state == FTX_DONE);
	assign start   = tx_req && !tx_busy;

	// Only content bytes come from the buffer.
	assign tx_byte = (state == FTX_BODY) ? data_q[idx] : FRAME_DELIM;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= FTX_IDLE;
			idx   <= '0;
			req   <= 1'b0;
		end else begin
			req <= 1'b0;
			case (state)
				FTX_IDLE, FTX_DONE: begin
					state <= start ? FTX_OPEN1 : FTX_IDLE;
					req   <= start;
				end
				FTX_OPEN1: if (byte_done) begin
					state <= FTX_OPEN2;
					req   <= 1'b1;
				end
				FTX_OPEN2: if (byte_done) begin
					// Empty content goes straight to the closing pair.
					state <= (len_q == '0) ? FTX_CLOSE1 : FTX_BODY;
					idx   <= '0;
					req   <= 1'b1;
				end
				FTX_BODY: if (byte_done) begin
					if (str_len_t'(idx + 1'b1) == len_q) begin
						state <= FTX_CLOSE1;
					end else begin
						idx <= idx + 1'b1;
					end
					req <= 1'b1;
				end
				FTX_CLOSE1: if (byte_done) begin
					state <= FTX_CLOSE2;
					req   <= 1'b1;
				end
				FTX_CLOSE2: if (byte_done) begin
					state <= FTX_DONE;
				end
				default: state <= FTX_IDLE;
			endcase
		end
	end

	// Caller may change tx_str once the request is taken.
	always_ff @(posedge sys_clk) begin
		if (start) begin
			data_q <= tx_str.data;
			len_q  <= tx_str.len;
		end
	end

endmodule

/* design/str_frame_pkg.sv */
// String framing definitions.
// Buffer layout, the '&' delimiter and the state encodings of the
// transmit and receive framers.

package str_frame_pkg;

	import uart_cfg_pkg::*;

	// Buffer capacity in bytes.
	localparam int STR_MAX_LEN = 32;

	// Opening and closing marks are two of these.
	localparam uart_byte_t FRAME_DELIM = 8'h26;

	// Counts 0 to STR_MAX_LEN inclusive.
	typedef logic [5:0] str_len_t;

	typedef struct packed {
		uart_byte_t [STR_MAX_LEN-1:0] data;  // Byte 0 in the low bits.
		str_len_t                     len;
		logic                         trunc;  // Bytes were dropped.
	} str_buf_t;

	typedef enum logic [3:0] {
		FTX_IDLE,
		FTX_OPEN1,
		FTX_OPEN2,
		FTX_BODY,
		FTX_CLOSE1,
		FTX_CLOSE2,
		FTX_DONE
	} ftx_state_t;

	typedef enum logic [2:0] {
		FRX_HUNT,
		FRX_OPEN2,
		FRX_BODY,
		FRX_AMP,   // One '&' seen inside the content.
		FRX_DONE
	} frx_state_t;

endpackage

/* design/uart_cfg_pkg.sv */
// UART line configuration.
// Bit timing of the 8N1 serial line and the character type shared by
// the byte-level transmitter, receiver and the string framers.

package uart_cfg_pkg;

	// sys_clk cycles per serial bit, kept small for short simulations.
	localparam int CLKS_PER_BIT = 16;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;  // Start bit midpoint.
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);

	// Start, 8 data and stop bit.
	localparam int FRAME_BITS = 10;

	typedef logic [CNT_W-1:0] bit_cnt_t;  // Cycle count within one bit.
	typedef logic [3:0]       bit_idx_t;  // Position within the serial frame.

	// One character on the line.
	typedef logic [7:0] uart_byte_t;

endpackage

/* design/uart_rx.sv */
// UART byte receiver.
// Synchronizes the serial input, finds the start edge, samples every bit
// at its middle and strobes vld for each byte with a good stop bit.

module uart_rx
	import uart_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output uart_byte_t rx_byte,
	output logic       vld
);

	logic rxd_meta;
	logic rxd_s;     // Synchronized line.
	logic rxd_d;     // One cycle older, for edge detection.
	logic active;
	bit_cnt_t clk_cnt;
	bit_idx_t bit_idx;

	logic fall;
	logic sample;
	logic is_start;
	logic is_stop;

	assign fall     = rxd_d && !rxd_s;
	assign is_start = (bit_idx == '0);
	assign is_stop  = (bit_idx == bit_idx_t'(FRAME_BITS - 1));

	// Start bit is sampled after half a bit, the rest a full bit apart.
	assign sample = active && (is_start ? (clk_cnt == bit_cnt_t'(HALF_BIT - 1))
					    : (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
			rxd_d    <= 1'b1;
			active   <= 1'b0;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			vld      <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
			rxd_d    <= rxd_s;
			vld      <= 1'b0;
			if (!active) begin
				if (fall) begin
					active  <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				if (is_start && rxd_s) begin
					active <= 1'b0;  // Line back high means a glitch.
				end else if (is_stop) begin
					active <= 1'b0;
					vld    <= rxd_s;  // Framing error drops the byte.
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// Data bits arrive LSB first.
	always_ff @(posedge sys_clk) begin
		if (sample && !is_start && !is_stop) begin
			rx_byte <= {rxd_s, rx_byte[7:1]};
		end
	end

endmodule

/* design/uart_string_link.sv */
// UART string link top level.
// Transmit framer feeding the UART transmitter, and the UART receiver
// feeding the receive framer.

module uart_string_link
	import uart_cfg_pkg::*;
	import str_frame_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst_n,

	input  str_buf_t tx_str,
	input  logic     tx_req,
	output logic     tx_busy,
	output logic     tx_done,

	output str_buf_t rx_str,
	output logic     rx_busy,
	output logic     rx_done,

	input  logic     uart_rx_port,
	output logic     uart_tx_port
);

	uart_byte_t ftx_byte;   // Framer to transmitter.
	logic       ftx_req;
	logic       utx_done;
	uart_byte_t urx_byte;   // Receiver to framer.
	logic       urx_vld;

	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_str    (tx_str),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.tx_byte   (ftx_byte),
		.req       (ftx_req),
		.byte_done (utx_done)
	);

	// Framer paces itself on done, so busy is left open.
	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_byte   (ftx_byte),
		.req       (ftx_req),
		.busy      (),
		.done      (utx_done),
		.txd       (uart_tx_port)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (urx_byte),
		.vld       (urx_vld)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (urx_byte),
		.vld       (urx_vld),
		.rx_str    (rx_str),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

/* design/uart_tx.sv */
// UART byte transmitter.
// Sends one 8N1 character per request, LSB first, and pulses done in the
// last cycle of the stop bit.

module uart_tx
	import uart_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  uart_byte_t tx_byte,
	input  logic       req,
	output logic       busy,
	output logic       done,
	output logic       txd
);

	bit_cnt_t   clk_cnt;
	bit_idx_t   bit_idx;
	uart_byte_t shift_q;

	logic bit_end;
	logic start;

	assign start   = req && !busy;  // Requests while busy are dropped.
	assign bit_end = busy && (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));
	assign done    = bit_end && (bit_idx == bit_idx_t'(FRAME_BITS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;  // Line idles high.
		end else if (start) begin
			busy    <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b0;  // Start bit.
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (done) begin
				busy <= 1'b0;
				txd  <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				// Ones shifted in behind the data give the stop bit.
				txd <= shift_q[0];
			end
		end else if (busy) begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Data shift register.
	always_ff @(posedge sys_clk) begin
		if (start) begin
			shift_q <= tx_byte;
		end else if (bit_end && !done) begin
			shift_q <= {1'b1, shift_q[7:1]};
		end
	end

endmodule

/* tests/uart_string_link_tb.sv */
// Testbench for the UART string link.
// Replays transmit and receive records from the data file through serial
// line models and checks framing, deframing and the done pulses.

module uart_string_link_tb
	import uart_cfg_pkg::*;
	import str_frame_pkg::*;
();

	logic     sys_clk;
	logic     sys_rst_n;
	str_buf_t tx_str;
	logic     tx_req;
	logic     tx_busy;
	logic     tx_done;
	str_buf_t rx_str;
	logic     rx_busy;
	logic     rx_done;
	logic     uart_rx_port;
	logic     uart_tx_port;

	int          value_errs = 0;
	int          proto_errs = 0;
	logic [31:0] lfsr_state;
	uart_byte_t  mon_q[$];      // Bytes decoded from uart_tx_port.
	int          rx_done_cnt = 0;
	str_buf_t    rx_got;        // rx_str seen with the last rx_done.
	byte         kind_q[$];
	str_buf_t    buf_q[$];      // Transmit string or expected result.
	int          raw_cnt_q[$];
	uart_byte_t  raw_q[$];
	int          total_bytes = 0;
	bit          wd_armed = 1'b0;
	longint      wd_limit;

	uart_string_link u_uart_string_link (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_str       (tx_str),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_str       (rx_str),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	initial begin
		wait (wd_armed);
		#(wd_limit);
		$display("Timeout: run did not finish within %0d time units", wd_limit);
		$display("** FAIL **");
		$finish;
	end

	// Serial monitor that samples each bit near its middle.
	initial begin
		uart_byte_t b;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge sys_clk);
			if (uart_tx_port === 1'b0) begin
				repeat (HALF_BIT) @(negedge sys_clk);
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge sys_clk);
					b[i] = uart_tx_port;  // LSB first.
				end
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				if (uart_tx_port !== 1'b1) begin
					proto_errs++;
					$display("Stop bit on uart_tx_port was low at time %0t", $time);
				end
				mon_q.push_back(b);
			end
		end
	end

	always @(negedge sys_clk) begin
		if (sys_rst_n === 1'b1 && rx_done === 1'b1) begin
			rx_done_cnt++;
			rx_got = rx_str;
		end
	end

	function automatic logic [31:0] galois_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = galois_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errs++;
			$display("Fail %s: expected %h, got %h at time %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			value_errs++;
			$display("Fail %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// Only bytes below the expected length carry content.
	task automatic check_buf(input string name, input str_buf_t exp, input str_buf_t act);
		for (int i = 0; i < int'(exp.len) && i < STR_MAX_LEN; i++) begin
			if (act.data[i] !== exp.data[i]) begin
				value_errs++;
				$display("Fail %s.data[%0d]: expected %h, got %h", name, i,
					exp.data[i], act.data[i]);
			end
		end
		if (act.len !== exp.len) begin
			value_errs++;
			$display("Fail %s.len: expected %h, got %h", name, exp.len, act.len);
		end
		if (act.trunc !== exp.trunc) begin
			value_errs++;
			$display("Fail %s.trunc: expected %h, got %h", name, exp.trunc, act.trunc);
		end
	endtask

	task automatic load_records();
		int       fd;
		int       code;
		int       n;
		int       v;
		string    tok;
		string    rest;
		str_buf_t sb;
		fd = $fopen("tests/uart_string_link_testdata.txt", "r");
		if (fd == 0) begin
			proto_errs++;
			$display("Could not open the test data file");
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			sb = '0;
			if (tok[0] == "#") begin
				code = $fgets(rest, fd);  // Comment line.
			end else if (tok == "T") begin
				code = $fscanf(fd, "%h", n);
				sb.len = str_len_t'(n);
				for (int i = 0; i < n; i++) begin
					code = $fscanf(fd, "%h", v);
					sb.data[i] = uart_byte_t'(v);
				end
				kind_q.push_back(tok[0]);
				buf_q.push_back(sb);
				raw_cnt_q.push_back(0);
				total_bytes += n + 4;  // Content plus four delimiters.
			end else if (tok == "R") begin
				code = $fscanf(fd, "%h", n);
				for (int i = 0; i < n; i++) begin
					code = $fscanf(fd, "%h", v);
					raw_q.push_back(uart_byte_t'(v));
				end
				raw_cnt_q.push_back(n);
				total_bytes += n;
				code = $fscanf(fd, "%h", v);
				sb.len = str_len_t'(v);
				code = $fscanf(fd, "%h", v);
				sb.trunc = v[0];
				for (int i = 0; i < int'(sb.len); i++) begin
					code = $fscanf(fd, "%h", v);
					sb.data[i] = uart_byte_t'(v);
				end
				kind_q.push_back(tok[0]);
				buf_q.push_back(sb);
			end else begin
				proto_errs++;
				$display("Unknown record type %s in the test data", tok);
			end
		end
		$fclose(fd);
	endtask

	// 8N1 driver followed by a random idle gap.
	task automatic send_serial_byte(input uart_byte_t b);
		int gap;
		uart_rx_port = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_port = b[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		uart_rx_port = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		draw_bits(3, gap);
		repeat (gap * CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic send_frame(input int rec, input str_buf_t s);
		uart_byte_t exp_q[$];
		int         limit;
		int         cycles;
		bit         seen;
		exp_q = {FRAME_DELIM, FRAME_DELIM};
		for (int i = 0; i < int'(s.len); i++) exp_q.push_back(s.data[i]);
		exp_q.push_back(FRAME_DELIM);
		exp_q.push_back(FRAME_DELIM);
		mon_q.delete();
		tx_str = s;
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		tx_str = ~s;  // Framer must have captured the string.
		check_bit("tx_busy", 1'b1, tx_busy);
		limit = exp_q.size() * (FRAME_BITS * CLKS_PER_BIT + 2) * 2;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
			tx_req = (cycles == 3 * CLKS_PER_BIT);  // Repeat request while busy.
			seen = tx_done;
			check_bit("tx_busy", !seen, tx_busy);
		end
		tx_req = 1'b0;
		if (!seen) begin
			proto_errs++;
			$display("Record %0d: tx_done did not pulse within %0d cycles", rec, limit);
		end
		repeat (2 * FRAME_BITS * CLKS_PER_BIT) begin
			@(negedge sys_clk);
			if (tx_done === 1'b1) begin
				proto_errs++;
				$display("Record %0d: tx_done pulsed more than once", rec);
			end
		end
		if (mon_q.size() != exp_q.size()) begin
			proto_errs++;
			$display("Record %0d: expected %0d bytes on uart_tx_port, saw %0d", rec,
				exp_q.size(), mon_q.size());
		end
		for (int i = 0; i < exp_q.size() && i < mon_q.size(); i++) begin
			check_byte("uart_tx_port", exp_q[i], mon_q[i]);
		end
	endtask

	task automatic receive_frame(input int rec, input int n, input str_buf_t exp);
		int base;
		int cycles;
		base = rx_done_cnt;
		for (int i = 0; i < n; i++) send_serial_byte(raw_q.pop_front());
		cycles = 0;
		while (rx_done_cnt == base && cycles < 4 * FRAME_BITS * CLKS_PER_BIT) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (rx_done_cnt == base) begin
			proto_errs++;
			$display("Record %0d: rx_done did not pulse after the frame", rec);
		end else begin
			repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
			if (rx_done_cnt - base != 1) begin
				proto_errs++;
				$display("Record %0d: rx_done pulsed %0d times", rec, rx_done_cnt - base);
			end
			check_buf("rx_str", exp, rx_got);
			check_bit("rx_busy", 1'b0, rx_busy);
		end
	endtask

	initial begin
		sys_rst_n = 1'b0;
		tx_req = 1'b0;
		tx_str = '0;
		uart_rx_port = 1'b1;  // Idle line.
		lfsr_state = 32'd95932;
		load_records();
		wd_limit = longint'(total_bytes) * FRAME_BITS * CLKS_PER_BIT * 40 * 3 + 200000;
		wd_armed = 1'b1;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_bit("tx_busy", 1'b0, tx_busy);
		check_bit("tx_done", 1'b0, tx_done);
		check_bit("rx_busy", 1'b0, rx_busy);
		check_bit("rx_done", 1'b0, rx_done);
		check_bit("uart_tx_port", 1'b1, uart_tx_port);
		check_buf("rx_str", '0, rx_str);
		// Every data byte is zero out of reset.
		for (int i = 0; i < STR_MAX_LEN; i++) begin
			check_byte("rx_str.data", '0, rx_str.data[i]);
		end
		for (int r = 0; r < kind_q.size(); r++) begin
			if (kind_q[r] == "T") send_frame(r, buf_q[r]);
			else receive_frame(r, raw_cnt_q[r], buf_q[r]);
		end
		repeat (4) @(negedge sys_clk);
		$display("Errors: %0d value mismatches, %0d protocol failures", value_errs,
			proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* tests/uart_string_link_testdata.txt */
# All numbers hex.  T len content : string to send on uart_tx_port.
# R count raw_bytes len trunc content : serial input and expected rx_str.
# Transmit "Hello".
T 05 48 65 6c 6c 6f
# Transmit an empty string.
T 00
# Transmit "a&b & c" with isolated ampersands.
T 07 61 26 62 20 26 20 63
# Transmit a full 32 byte string.
T 20 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46
     47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56
# Receive "Hi".
R 06 26 26 48 69 26 26  02 0 48 69
# Receive an empty frame.
R 04 26 26 26 26  00 0
# Receive "a&b&c".
R 09 26 26 61 26 62 26 63 26 26  05 0 61 26 62 26 63
# Junk "xy", false start "&Q", then "ok".
R 0a 78 79 26 51 26 26 6f 6b 26 26  02 0 6f 6b
# Content that opens with an ampersand, "&x".
R 06 26 26 26 78 26 26  02 0 26 78
# 34 content bytes, only the first 32 kept.
R 26 26 26 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46 47 48
     49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 26 26
     20 1 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46
          47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56
# 31 bytes then "&z", the held ampersand fills the last slot.
R 25 26 26 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46 47 48
     49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 26 7a 26 26
     20 1 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46
          47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 26
# Normal frame "Hello" after the overflows.
R 09 26 26 48 65 6c 6c 6f 26 26  05 0 48 65 6c 6c 6f

/* uart_string_link.f */
design/uart_cfg_pkg.sv
design/str_frame_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/frame_tx.sv
design/frame_rx.sv
design/uart_string_link.sv
tests/uart_string_link_tb.sv
